//--- project.f
+incdir+tb
hw/cpu_pkg.sv
hw/decoder.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/alu.sv
hw/barrel_shifter.sv
hw/forward_unit.sv
hw/execute_stage.sv
hw/pipeline.sv
tb/pipeline_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module pipeline_tb -o pipeline_sim &&
./obj_dir/pipeline_sim | tee sim.log &&
grep -q "ALL TESTS PASSED" sim.log &&
! grep -q "SOME TESTS FAILED" sim.log &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tb/ref_model.svh
// Function codes and I-type opcodes for random picks, index 0 is the last entry
localparam logic [14*6-1:0] fn_list = {fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav,
                                       fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor,
                                       fn_slt, fn_sltu};
localparam logic [7*6-1:0]  op_list = {op_addiu, op_slti, op_sltiu, op_andi, op_ori,
                                       op_xori, op_lui};

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic word_t r_word(input logic [5:0] fn, input reg_addr_t rs,
                                 input reg_addr_t rt, input reg_addr_t rd,
                                 input logic [4:0] sh);
    return {op_special, rs, rt, rd, sh, fn};
endfunction

function automatic word_t i_word(input logic [5:0] op, input reg_addr_t rs,
                                 input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// Random word over $0..$7, so $0 destinations and dependencies are frequent
function automatic word_t random_word(input logic [31:0] r, input logic [31:0] s);
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     w;
    rs = {2'b00, r[12:10]};
    rt = {2'b00, r[15:13]};
    rd = {2'b00, r[18:16]};
    case (r[31:30])
        2'd0, 2'd1: w = r_word(fn_list[6*(s[11:8] % 14) +: 6], rs, rt, rd, r[23:19]);
        2'd2: begin
            w = i_word(op_list[6*(s[7:4] % 7) +: 6], rs, rt, s[31:16]);
            if (w[31:26] == op_lui) begin
                w[25:21] = 5'd0;
            end
        end
        default: begin
            // Opcodes 0x20-0x27 and function codes 0x10-0x1f are not implemented
            if (r[29]) begin
                w = i_word({3'b100, s[2:0]}, rs, rt, s[31:16]);
            end else begin
                w = r_word({2'b01, s[3:0]}, rs, rt, rd, r[23:19]);
            end
        end
    endcase
    return w;
endfunction

// Architectural effect of one word on register state rf
function automatic logic ref_exec(input logic [31:0][31:0] rf, input word_t w,
                                  output reg_addr_t dest, output word_t val);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] zx;
    logic        ok;
    a    = rf[w[25:21]];
    b    = rf[w[20:16]];
    sx   = {{16{w[15]}}, w[15:0]};
    zx   = {16'h0000, w[15:0]};
    ok   = 1'b1;
    val  = '0;
    dest = (w[31:26] == op_special) ? w[15:11] : w[20:16];
    if (w[31:26] == op_special) begin
        case (w[5:0])
            fn_sll:  val = b << w[10:6];
            fn_srl:  val = b >> w[10:6];
            fn_sra:  val = $signed(b) >>> w[10:6];
            fn_sllv: val = b << a[4:0];
            fn_srlv: val = b >> a[4:0];
            fn_srav: val = $signed(b) >>> a[4:0];
            fn_addu: val = a + b;
            fn_subu: val = a - b;
            fn_and:  val = a & b;
            fn_or:   val = a | b;
            fn_xor:  val = a ^ b;
            fn_nor:  val = ~(a | b);
            fn_slt:  val = {31'd0, $signed(a) < $signed(b)};
            fn_sltu: val = {31'd0, a < b};
            default: ok = 1'b0;
        endcase
    end else begin
        case (w[31:26])
            op_addiu: val = a + sx;
            op_slti:  val = {31'd0, $signed(a) < $signed(sx)};
            op_sltiu: val = {31'd0, a < sx};
            op_andi:  val = a & zx;
            op_ori:   val = a | zx;
            op_xori:  val = a ^ zx;
            op_lui: begin
                val = {w[15:0], 16'h0000};
                ok  = (w[25:21] == 5'd0);
            end
            default:  ok = 1'b0;
        endcase
    end
    return ok && (dest != 5'd0);
endfunction

//--- tb/pipeline_tb.sv
`timescale 1ns/1ps

module pipeline_tb;
    import cpu_pkg::*;

    `include "ref_model.svh"

    // About 790 cycles of stimulus in all
    localparam int max_cycles = 2000;

    logic      clk;
    logic      rst;
    word_t     instr;
    logic      wb_reg_w;
    reg_addr_t wb_rd_addr;
    word_t     wb_data;

    logic [31:0][31:0] model_rf;
    reg_addr_t         exp_addr_q[$];
    word_t             exp_data_q[$];
    logic [31:0]       seed;
    int                cycles = 0;
    int                errors = 0;
    int                test_errors = 0;
    int                pass_count = 0;
    int                fail_count = 0;

    pipeline dut_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .instr      ( instr      ),
        .wb_reg_w   ( wb_reg_w   ),
        .wb_rd_addr ( wb_rd_addr ),
        .wb_data    ( wb_data    )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Write-port checker
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        reg_addr_t exp_a;
        word_t     exp_d;
        if (rst) begin
            if (wb_reg_w === 1'b1) begin
                $display("A register write appeared during reset at time %0t", $time);
                errors++;
            end
        end else if (wb_reg_w === 1'b1) begin
            if (exp_addr_q.size() == 0) begin
                $display("Unexpected write to $%0d at time %0t, none was pending",
                         wb_rd_addr, $time);
                errors++;
            end else begin
                exp_a = exp_addr_q.pop_front();
                exp_d = exp_data_q.pop_front();
                if (wb_rd_addr !== exp_a || wb_data !== exp_d) begin
                    $display("Fail at %0t: expected $%0d = %08h, got $%0d = %08h",
                             $time, exp_a, exp_d, wb_rd_addr, wb_data);
                    errors++;
                end
            end
        end else if (wb_reg_w !== 1'b0) begin
            $display("wb_reg_w is unknown at time %0t", $time);
            errors++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    task automatic drive(input word_t w);
        reg_addr_t d;
        word_t     v;
        @(negedge clk);
        instr = w;
        if (ref_exec(model_rf, w, d, v)) begin
            model_rf[d] = v;
            exp_addr_q.push_back(d);
            exp_data_q.push_back(v);
        end
    endtask

    // Three bubbles keep the word clear of any forwarding
    task automatic spaced(input word_t w);
        drive(w);
        repeat (3) drive('0);
    endtask

    task automatic load_reg(input reg_addr_t r, input word_t value);
        spaced(i_word(op_lui, 5'd0, r, value[31:16]));
        spaced(i_word(op_ori, r, r, value[15:0]));
    endtask

    task automatic end_test(input string name);
        repeat (6) drive('0);
        if (exp_addr_q.size() != 0) begin
            $display("%0d expected writes never arrived in test %s", exp_addr_q.size(), name);
            errors++;
            exp_addr_q.delete();
            exp_data_q.delete();
        end
        if (errors == test_errors) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        instr    = '0;
        rst      = 1'b1;
        model_rf = '0;
        seed     = 32'h778c_8c91;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (12) drive('0);
        end_test("reset_idle");

        load_reg(5'd1, 32'h8000_1234);
        load_reg(5'd2, 32'h0000_0042);
        load_reg(5'd3, 32'hffff_fff0);
        load_reg(5'd4, 32'h7fff_0f0f);
        load_reg(5'd5, 32'hffff_ff23);
        // Negative against positive, then both negative
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < 8; i++) begin
                spaced(r_word(fn_list[i*6 +: 6], (p == 0) ? 5'd1 : 5'd3,
                              (p == 0) ? 5'd2 : 5'd1, 5'(10 + 8*p + i), 5'd0));
            end
        end
        end_test("r_type_alu");

        // Variable amounts come from $5 (low bits 3) and $2 (low bits 2)
        for (int i = 8; i < 14; i++) begin
            spaced(r_word(fn_list[i*6 +: 6], 5'd5, 5'd1, 5'(i + 2), 5'd7));
            spaced(r_word(fn_list[i*6 +: 6], 5'd2, 5'd3, 5'(i + 12), 5'd31));
            spaced(r_word(fn_list[i*6 +: 6], 5'd0, 5'd4, 5'(i + 18), 5'd0));
        end
        end_test("shifts");

        spaced(i_word(op_addiu, 5'd2, 5'd20, 16'hfff0));
        spaced(i_word(op_slti, 5'd2, 5'd21, 16'h8000));
        spaced(i_word(op_sltiu, 5'd4, 5'd22, 16'h8000));
        spaced(i_word(op_andi, 5'd1, 5'd23, 16'hf0f0));
        spaced(i_word(op_ori, 5'd2, 5'd24, 16'h8001));
        spaced(i_word(op_xori, 5'd3, 5'd25, 16'hffff));
        spaced(i_word(op_lui, 5'd0, 5'd26, 16'h8765));
        end_test("immediates");

        // Distance 1 hits MEM, 2 hits WB, 3 hits the register file bypass
        for (int d = 1; d <= 3; d++) begin
            drive(r_word(fn_addu, 5'd1, 5'd2, 5'd7, 5'd0));
            repeat (d - 1) drive('0);
            drive(r_word(fn_subu, 5'd7, 5'd3, 5'd8, 5'd0));
            repeat (d - 1) drive('0);
            drive(r_word(fn_xor, 5'd2, 5'd8, 5'd9, 5'd0));
            repeat (d - 1) drive('0);
            drive(r_word(fn_srav, 5'd9, 5'd1, 5'd7, 5'd0));
        end
        for (int i = 0; i < 6; i++) begin
            drive(i_word(op_addiu, 5'd6, 5'd6, 16'h0123));
        end
        end_test("dependent_chains");

        for (int n = 0; n < 500; n++) begin
            seed = lcg_next(seed);
            r    = seed;
            seed = lcg_next(seed);
            s    = seed;
            drive(random_word(r, s));
        end
        end_test("random_stream");

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- hw/pipeline.sv
`timescale 1ns/1ps

module pipeline (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::word_t     instr,
    output logic               wb_reg_w,
    output cpu_pkg::reg_addr_t wb_rd_addr,
    output cpu_pkg::word_t     wb_data
);
    import cpu_pkg::*;

    ////////////////////////////////////////////////////////////
    // ID/EX wires
    ////////////////////////////////////////////////////////////
    alu_op_t    ex_alu_op;
    shift_op_t  ex_shift_op;
    exres_sel_t ex_exres_sel;
    logic       ex_b_is_imm;
    logic       ex_shamt_from_reg;
    logic [4:0] ex_shamt;
    logic       ex_reg_w;
    word_t      ex_op_a, ex_op_b, ex_imm;
    reg_addr_t  ex_rs_addr, ex_rt_addr, ex_rd_addr;

    decode_stage decode_i (
        .clk            ( clk               ),
        .rst            ( rst               ),
        .instr          ( instr             ),
        .wb_reg_w       ( wb_reg_w          ),
        .wb_rd_addr     ( wb_rd_addr        ),
        .wb_data        ( wb_data           ),
        .alu_op         ( ex_alu_op         ),
        .shift_op       ( ex_shift_op       ),
        .exres_sel      ( ex_exres_sel      ),
        .b_is_imm       ( ex_b_is_imm       ),
        .shamt_from_reg ( ex_shamt_from_reg ),
        .shamt          ( ex_shamt          ),
        .reg_w          ( ex_reg_w          ),
        .op_a           ( ex_op_a           ),
        .op_b           ( ex_op_b           ),
        .imm            ( ex_imm            ),
        .rs_addr        ( ex_rs_addr        ),
        .rt_addr        ( ex_rt_addr        ),
        .rd_addr        ( ex_rd_addr        )
    );

    // Write port of WB feeds back to the register file
    execute_stage execute_i (
        .clk            ( clk               ),
        .rst            ( rst               ),
        .alu_op         ( ex_alu_op         ),
        .shift_op       ( ex_shift_op       ),
        .exres_sel      ( ex_exres_sel      ),
        .b_is_imm       ( ex_b_is_imm       ),
        .shamt_from_reg ( ex_shamt_from_reg ),
        .shamt          ( ex_shamt          ),
        .reg_w          ( ex_reg_w          ),
        .op_a           ( ex_op_a           ),
        .op_b           ( ex_op_b           ),
        .imm            ( ex_imm            ),
        .rs_addr        ( ex_rs_addr        ),
        .rt_addr        ( ex_rt_addr        ),
        .rd_addr        ( ex_rd_addr        ),
        .wb_reg_w       ( wb_reg_w          ),
        .wb_rd_addr     ( wb_rd_addr        ),
        .wb_data        ( wb_data           )
    );

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::alu_op_t    alu_op,
    input  cpu_pkg::shift_op_t  shift_op,
    input  cpu_pkg::exres_sel_t exres_sel,
    input  logic                b_is_imm,
    input  logic                shamt_from_reg,
    input  logic [4:0]          shamt,
    input  logic                reg_w,
    input  cpu_pkg::word_t      op_a,
    input  cpu_pkg::word_t      op_b,
    input  cpu_pkg::word_t      imm,
    input  cpu_pkg::reg_addr_t  rs_addr,
    input  cpu_pkg::reg_addr_t  rt_addr,
    input  cpu_pkg::reg_addr_t  rd_addr,
    output logic                wb_reg_w,
    output cpu_pkg::reg_addr_t  wb_rd_addr,
    output cpu_pkg::word_t      wb_data
);
    import cpu_pkg::*;

    fwd_sel_t   a_sel, b_sel;
    word_t      fwd_a, fwd_b;
    word_t      alu_b;
    logic [4:0] amount;
    word_t      alu_y, shift_y, ex_result;
    logic       mem_reg_w;
    reg_addr_t  mem_rd_addr;
    word_t      mem_data;

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////
    forward_unit forward_unit_i (
        .rs_addr     ( rs_addr     ),
        .rt_addr     ( rt_addr     ),
        .mem_reg_w   ( mem_reg_w   ),
        .mem_rd_addr ( mem_rd_addr ),
        .wb_reg_w    ( wb_reg_w    ),
        .wb_rd_addr  ( wb_rd_addr  ),
        .a_sel       ( a_sel       ),
        .b_sel       ( b_sel       )
    );

    assign fwd_a = (a_sel == fwd_mem) ? mem_data : (a_sel == fwd_wb) ? wb_data : op_a;
    assign fwd_b = (b_sel == fwd_mem) ? mem_data : (b_sel == fwd_wb) ? wb_data : op_b;

    assign alu_b  = b_is_imm ? imm : fwd_b;
    // Variable shifts use rs[4:0]
    assign amount = shamt_from_reg ? fwd_a[4:0] : shamt;

    alu alu_i (
        .a  ( fwd_a  ),
        .b  ( alu_b  ),
        .op ( alu_op ),
        .y  ( alu_y  )
    );

    barrel_shifter shifter_i (
        .d      ( fwd_b    ),
        .amount ( amount   ),
        .op     ( shift_op ),
        .y      ( shift_y  )
    );

    assign ex_result = (exres_sel == exres_shift) ? shift_y : alu_y;

    ////////////////////////////////////////////////////////////
    // EX/MEM and MEM/WB
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_reg_w   <= 1'b0;
            mem_rd_addr <= '0;
            mem_data    <= '0;
            wb_reg_w    <= 1'b0;
            wb_rd_addr  <= '0;
            wb_data     <= '0;
        end else begin
            mem_reg_w   <= reg_w;
            mem_rd_addr <= rd_addr;
            mem_data    <= ex_result;
            // MEM does no work of its own
            wb_reg_w    <= mem_reg_w;
            wb_rd_addr  <= mem_rd_addr;
            wb_data     <= mem_data;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !mem_reg_w |-> (a_sel != fwd_mem && b_sel != fwd_mem));

endmodule

//--- hw/forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  logic               mem_reg_w,
    input  cpu_pkg::reg_addr_t mem_rd_addr,
    input  logic               wb_reg_w,
    input  cpu_pkg::reg_addr_t wb_rd_addr,
    output cpu_pkg::fwd_sel_t  a_sel,
    output cpu_pkg::fwd_sel_t  b_sel
);
    import cpu_pkg::*;

    // Youngest producer wins
    function automatic fwd_sel_t pick(input reg_addr_t src);
        fwd_sel_t sel;
        if (mem_reg_w && mem_rd_addr == src) begin
            sel = fwd_mem;
        end else if (wb_reg_w && wb_rd_addr == src) begin
            sel = fwd_wb;
        end else begin
            sel = fwd_idex;
        end
        return sel;
    endfunction

    assign a_sel = pick(rs_addr);
    assign b_sel = pick(rt_addr);

endmodule

//--- hw/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter (
    input  cpu_pkg::word_t     d,
    input  logic [4:0]         amount,
    input  cpu_pkg::shift_op_t op,
    output cpu_pkg::word_t     y
);
    import cpu_pkg::*;

    logic                      left;
    logic                      fill;
    logic [2*data_width-1:0]   w1, w2, w3;
    word_t                     s1, s2;

    assign left = (op == shift_sll);
    assign fill = (op == shift_sra) & d[data_width-1];

    // Right shifts run on a word extended by the fill bit
    assign w1 = {{data_width{fill}}, d}  >> {amount[4:3], 3'b000};
    assign s1 = left ? d << {amount[4:3], 3'b000} : w1[data_width-1:0];
    assign w2 = {{data_width{fill}}, s1} >> {amount[2:1], 1'b0};
    assign s2 = left ? s1 << {amount[2:1], 1'b0} : w2[data_width-1:0];
    assign w3 = {{data_width{fill}}, s2} >> amount[0];
    assign y  = left ? s2 << amount[0] : w3[data_width-1:0];

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   y
);
    import cpu_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:  y = a + b;
            alu_sub:  y = a - b;
            alu_and:  y = a & b;
            alu_or:   y = a | b;
            alu_xor:  y = a ^ b;
            alu_nor:  y = ~(a | b);
            // Compares give 0 or 1
            alu_slt:  y = {{(data_width-1){1'b0}}, lt_signed};
            alu_sltu: y = {{(data_width-1){1'b0}}, lt_unsigned};
            default:  y = '0;
        endcase
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::word_t      instr,
    input  logic                wb_reg_w,
    input  cpu_pkg::reg_addr_t  wb_rd_addr,
    input  cpu_pkg::word_t      wb_data,
    output cpu_pkg::alu_op_t    alu_op,
    output cpu_pkg::shift_op_t  shift_op,
    output cpu_pkg::exres_sel_t exres_sel,
    output logic                b_is_imm,
    output logic                shamt_from_reg,
    output logic [4:0]          shamt,
    output logic                reg_w,
    output cpu_pkg::word_t      op_a,
    output cpu_pkg::word_t      op_b,
    output cpu_pkg::word_t      imm,
    output cpu_pkg::reg_addr_t  rs_addr,
    output cpu_pkg::reg_addr_t  rt_addr,
    output cpu_pkg::reg_addr_t  rd_addr
);
    import cpu_pkg::*;

    word_t      ifid_instr;
    alu_op_t    id_alu_op;
    shift_op_t  id_shift_op;
    exres_sel_t id_exres_sel;
    imm_ext_t   id_imm_ext;
    logic       id_b_is_imm;
    logic       id_shamt_from_reg;
    logic       id_rd_is_rt;
    logic       id_supported;
    word_t      id_rs_data;
    word_t      id_rt_data;
    word_t      id_imm;
    reg_addr_t  id_dest;
    logic       id_reg_w;

    ////////////////////////////////////////////////////////////
    // IF/ID
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ifid_instr <= '0;
        end else begin
            ifid_instr <= instr;
        end
    end

    decoder decoder_i (
        .instr          ( ifid_instr        ),
        .alu_op         ( id_alu_op         ),
        .shift_op       ( id_shift_op       ),
        .exres_sel      ( id_exres_sel      ),
        .imm_ext        ( id_imm_ext        ),
        .b_is_imm       ( id_b_is_imm       ),
        .shamt_from_reg ( id_shamt_from_reg ),
        .rd_is_rt       ( id_rd_is_rt       ),
        .supported      ( id_supported      )
    );

    reg_file reg_file_i (
        .clk     ( clk                ),
        .rst     ( rst                ),
        .rs_addr ( ifid_instr[25:21]  ),
        .rt_addr ( ifid_instr[20:16]  ),
        .rs_data ( id_rs_data         ),
        .rt_data ( id_rt_data         ),
        .w_en    ( wb_reg_w           ),
        .w_addr  ( wb_rd_addr         ),
        .w_data  ( wb_data            )
    );

    always_comb begin
        case (id_imm_ext)
            ext_sign:  id_imm = {{16{ifid_instr[15]}}, ifid_instr[15:0]};
            ext_upper: id_imm = {ifid_instr[15:0], 16'h0000};
            default:   id_imm = {16'h0000, ifid_instr[15:0]};
        endcase
    end

    // Destination and write gating
    assign id_dest  = id_rd_is_rt ? ifid_instr[20:16] : ifid_instr[15:11];
    assign id_reg_w = id_supported && (id_dest != '0);

    ////////////////////////////////////////////////////////////
    // ID/EX
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_op         <= alu_add;
            shift_op       <= shift_sll;
            exres_sel      <= exres_alu;
            b_is_imm       <= 1'b0;
            shamt_from_reg <= 1'b0;
            shamt          <= '0;
            reg_w          <= 1'b0;
            op_a           <= '0;
            op_b           <= '0;
            imm            <= '0;
            rs_addr        <= '0;
            rt_addr        <= '0;
            rd_addr        <= '0;
        end else begin
            alu_op         <= id_alu_op;
            shift_op       <= id_shift_op;
            exres_sel      <= id_exres_sel;
            b_is_imm       <= id_b_is_imm;
            shamt_from_reg <= id_shamt_from_reg;
            shamt          <= ifid_instr[10:6];
            reg_w          <= id_reg_w;
            op_a           <= id_rs_data;
            op_b           <= id_rt_data;
            imm            <= id_imm;
            rs_addr        <= ifid_instr[25:21];
            rt_addr        <= ifid_instr[20:16];
            rd_addr        <= id_dest;
        end
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    input  logic               w_en,
    input  cpu_pkg::reg_addr_t w_addr,
    input  cpu_pkg::word_t     w_data
);
    import cpu_pkg::*;

    word_t regs [2**reg_addr_width];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en) begin
            regs[w_addr] <= w_data;
        end
    end

    // $0 reads zero, a same-cycle write is passed straight through
    assign rs_data = (rs_addr == '0) ? '0 :
                     (w_en && w_addr == rs_addr) ? w_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (w_en && w_addr == rt_addr) ? w_data : regs[rt_addr];

    // Writes to $0 are dropped in decode
    assert property (@(posedge clk) disable iff (rst) w_en |-> w_addr != '0);

endmodule

//--- hw/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::word_t      instr,
    output cpu_pkg::alu_op_t    alu_op,
    output cpu_pkg::shift_op_t  shift_op,
    output cpu_pkg::exres_sel_t exres_sel,
    output cpu_pkg::imm_ext_t   imm_ext,
    output logic                b_is_imm,
    output logic                shamt_from_reg,
    output logic                rd_is_rt,
    output logic                supported
);
    import cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        alu_op         = alu_add;
        shift_op       = shift_sll;
        exres_sel      = exres_alu;
        imm_ext        = ext_zero;
        b_is_imm       = 1'b0;
        shamt_from_reg = 1'b0;
        rd_is_rt       = 1'b0;
        supported      = 1'b1;
        // I-type writes rt and takes the immediate as B
        if (opcode != op_special) begin
            rd_is_rt = 1'b1;
            b_is_imm = 1'b1;
        end
        case (opcode)
            op_special: begin
                case (funct)
                    fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav: begin
                        exres_sel = exres_shift;
                        // funct[2] marks the variable forms
                        shamt_from_reg = funct[2];
                        if (funct[1:0] == 2'b11) begin
                            shift_op = shift_sra;
                        end else if (funct[1]) begin
                            shift_op = shift_srl;
                        end
                    end
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    default: supported = 1'b0;
                endcase
            end
            op_addiu: imm_ext = ext_sign;
            op_slti: begin
                alu_op  = alu_slt;
                imm_ext = ext_sign;
            end
            op_sltiu: begin
                alu_op  = alu_sltu;
                imm_ext = ext_sign;
            end
            op_andi: alu_op = alu_and;
            op_ori:  alu_op = alu_or;
            op_xori: alu_op = alu_xor;
            op_lui: begin
                // $0 OR upper immediate; a nonzero rs field is not a valid LUI
                alu_op    = alu_or;
                imm_ext   = ext_upper;
                supported = (instr[25:21] == 5'd0);
            end
            default: supported = 1'b0;
        endcase
    end

endmodule

//--- hw/cpu_pkg.sv
package cpu_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;

    typedef logic [data_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt, alu_sltu
    } alu_op_t;

    typedef enum logic [1:0] {shift_sll, shift_srl, shift_sra} shift_op_t;
    typedef enum logic [1:0] {ext_zero, ext_sign, ext_upper} imm_ext_t;
    typedef enum logic {exres_alu, exres_shift} exres_sel_t;
    typedef enum logic [1:0] {fwd_idex, fwd_mem, fwd_wb} fwd_sel_t;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;

    // SPECIAL function codes
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

endpackage
